// ==== flist.f ====
+incdir+.
joy_pkg.sv
joy_source_select.sv
joy_player_map.sv
joy_port_reader.sv
joy_port_hub.sv
tb_joy_port_hub.sv

// ==== tb_joy_port_hub.sv ====
`timescale 1ns/10ps
`include "joy_defs.svh"

module tb_joy_port_hub;

	logic                     clk_sys;
	logic                     reset;
	joy_pkg::joy_cfg_t        cfg;
	joy_pkg::joy_state_t      usb_joy [0:`JOY_PLAYERS-1];
	logic [`EXT_RAW_BITS-1:0] ext_raw [0:`JOY_PLAYERS-1];
	joy_pkg::io_req_t         req;
	logic [`KEY_ROW_BITS-1:0] key_data;
	logic                     ear_in;
	logic [7:0]               rd_data;
	logic                     rd_valid;

	int errors;
	int checks;
	int seed;

	// ====================
	// Test table
	// ====================

	// usb and ext columns hold player 1 in the upper half
	string       t_name [0:31];
	logic [5:0]  t_cfg  [0:31];
	logic [11:0] t_usb  [0:31];
	logic [13:0] t_ext  [0:31];
	logic [4:0]  t_key  [0:31];
	logic        t_ear  [0:31];
	logic [15:0] t_addr [0:31];
	logic [7:0]  t_exp  [0:31];
	int          num_rows;

	joy_port_hub UUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cfg      (cfg),
		.usb_joy  (usb_joy),
		.ext_raw  (ext_raw),
		.req      (req),
		.key_data (key_data),
		.ear_in   (ear_in),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================
	// Reference model
	// ====================

	// Connector word to right left down up fire1 fire2
	function automatic logic [5:0] ext_state(input logic [6:0] raw, input logic menu);
		if (menu)
			return 6'h00;
		return {raw[6], raw[4] | raw[5], raw[3:0]};
	endfunction

	// Returns kempston, keys 6..0 row, keys 5..1 row
	function automatic logic [15:0] player_keys(input logic [2:0] mode, input logic [5:0] st,
		input logic first);
		logic [4:0] sin1;
		logic [4:0] sin2;
		sin1 = {st[1], st[0], st[2], st[3], st[4]};
		sin2 = {st[4], st[3], st[2], st[0], st[1]};
		case (mode)
			3'd0: return {st, 10'h000};
			3'd1: return {6'h00, sin1, 5'h00};
			3'd2: return {6'h00, 5'h00, sin2};
			3'd3: return first ? {6'h00, sin1, 5'h00} : {6'h00, 5'h00, sin2};
			3'd4: return {6'h00, st[2], st[3], st[0], 1'b0, st[4], st[1], 4'h0};
			default: return 16'h0000;
		endcase
	endfunction

	function automatic logic [7:0] expected_byte(input logic [5:0] c, input logic [11:0] usb,
		input logic [13:0] ext, input logic [4:0] key, input logic ear, input logic [15:0] addr);
		logic [5:0]  st0;
		logic [5:0]  st1;
		logic [15:0] km;
		logic [4:0]  row;
		// Field order mode, ext_enable, two players, menu
		if (!c[2]) begin
			st0 = usb[5:0];
			st1 = usb[11:6];
		end else begin
			st0 = ext_state(ext[6:0], c[0]);
			st1 = c[1] ? ext_state(ext[13:7], c[0]) : usb[5:0];
		end
		km = player_keys(c[5:3], st0, 1'b1) | player_keys(c[5:3], st1, 1'b0);
		row = key;
		if (!addr[12])
			row = row & ~km[9:5];
		if (!addr[11])
			row = row & ~km[4:0];
		if (addr[5:0] == 6'h1F)
			return {2'b00, km[15:10]};
		else if (!addr[0])
			return {1'b1, ear, 1'b1, row};
		else
			return 8'hFF;
	endfunction

	task automatic add_row(input string name, input logic [5:0] c, input logic [11:0] usb,
		input logic [13:0] ext, input logic [4:0] key, input logic ear, input logic [15:0] addr);
		t_name[num_rows] = name;
		t_cfg[num_rows]  = c;
		t_usb[num_rows]  = usb;
		t_ext[num_rows]  = ext;
		t_key[num_rows]  = key;
		t_ear[num_rows]  = ear;
		t_addr[num_rows] = addr;
		t_exp[num_rows]  = expected_byte(c, usb, ext, key, ear, addr);
		num_rows++;
	endtask

	// ====================
	// Driving and checking
	// ====================

	// Entered 1 ns after a rising edge
	task automatic apply_row(input int i);
		cfg        = t_cfg[i];
		usb_joy[0] = t_usb[i][5:0];
		usb_joy[1] = t_usb[i][11:6];
		ext_raw[0] = t_ext[i][6:0];
		ext_raw[1] = t_ext[i][13:7];
		key_data   = t_key[i];
		ear_in     = t_ear[i];
		repeat (3) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic read_check(input string name, input logic [15:0] addr, input logic [7:0] exp);
		int wait_cycles;
		wait_cycles = 0;
		req.rd   = 1'b1;
		req.addr = addr;
		@(posedge clk_sys);
		#1;
		req.rd = 1'b0;
		while (!rd_valid && wait_cycles < 10) begin
			@(posedge clk_sys);
			#1;
			wait_cycles++;
		end
		checks++;
		if (!rd_valid) begin
			$display("%s: no read response within 10 cycles", name);
			errors++;
		end else if (rd_data !== exp) begin
			$display("error %s expected %h actual %h", name, exp, rd_data);
			errors++;
		end
	endtask

	initial begin
		logic [31:0] r_word;
		logic [15:0] r_addr;
		logic [5:0]  r_cfg;
		logic [11:0] r_usb;
		logic [13:0] r_ext;
		logic [4:0]  r_key;
		logic        r_ear;
		errors   = 0;
		checks   = 0;
		num_rows = 0;
		seed     = 32'h4602_0bf3;
		reset    = 1'b1;
		cfg      = '0;
		req      = '0;
		key_data = 5'h1F;
		ear_in   = 1'b0;
		for (int p = 0; p < `JOY_PLAYERS; p++) begin
			usb_joy[p] = '0;
			ext_raw[p] = '0;
		end

		// Mode 0 kempston 1 sinclair1 2 sinclair2 3 dual 4 cursor
		add_row("reset_kempston", 6'h00, 12'h000, 14'h0000, 5'h1F, 1'b0, 16'h001F);
		add_row("kempston_or", 6'h00, {6'h12, 6'h05}, 14'h0000, 5'h1F, 1'b0, 16'h001F);
		add_row("sinclair1_efe", 6'h08, {6'h00, 6'h1A}, 14'h0000, 5'h1F, 1'b1, 16'hEFFE);
		add_row("sinclair1_f7fe", 6'h08, {6'h00, 6'h1A}, 14'h0000, 5'h1F, 1'b0, 16'hF7FE);
		add_row("sinclair2_f7fe", 6'h10, {6'h00, 6'h15}, 14'h0000, 5'h1B, 1'b0, 16'hF7FE);
		add_row("sinclair12_efe", 6'h18, {6'h13, 6'h09}, 14'h0000, 5'h1F, 1'b1, 16'hEFFE);
		add_row("sinclair12_f7fe", 6'h18, {6'h13, 6'h09}, 14'h0000, 5'h1F, 1'b1, 16'hF7FE);
		add_row("unaddressed_row", 6'h08, {6'h1F, 6'h1F}, 14'h0000, 5'h0A, 1'b1, 16'hFEFE);
		add_row("cursor_efe", 6'h20, {6'h00, 6'h1D}, 14'h0000, 5'h1F, 1'b0, 16'hEFFE);
		add_row("cursor_f7fe", 6'h20, {6'h00, 6'h02}, 14'h0000, 5'h1F, 1'b0, 16'hF7FE);
		add_row("cursor_kempston", 6'h20, {6'h3F, 6'h3F}, 14'h0000, 5'h1F, 1'b0, 16'h001F);
		add_row("ext_two_players", 6'h06, {6'h3F, 6'h3F}, {7'h48, 7'h21}, 5'h1F, 1'b0, 16'h001F);
		add_row("ext_menu_blank", 6'h07, {6'h3F, 6'h3F}, {7'h48, 7'h21}, 5'h1F, 1'b0, 16'h001F);
		add_row("ext_one_player", 6'h04, {6'h20, 6'h04}, {7'h7F, 7'h10}, 5'h1F, 1'b0, 16'h001F);
		add_row("other_port_ff", 6'h00, {6'h3F, 6'h3F}, 14'h0000, 5'h00, 1'b0, 16'h00FF);
		add_row("other_port_7ffd", 6'h08, {6'h3F, 6'h3F}, 14'h0000, 5'h00, 1'b1, 16'h7FFD);

		// Random rows also reach modes 5 to 7
		for (int i = 0; i < 8; i++) begin
			r_word = $random(seed);
			r_addr = r_word[15:0];
			if (i % 4 == 3)
				r_addr[5:0] = 6'h1F;
			else if (i % 2 == 0)
				r_addr[0] = 1'b0;
			r_word = $random(seed);
			r_cfg  = r_word[5:0];
			r_word = $random(seed);
			r_usb  = r_word[11:0];
			r_word = $random(seed);
			r_ext  = r_word[13:0];
			r_word = $random(seed);
			r_key  = r_word[4:0];
			r_word = $random(seed);
			r_ear  = r_word[0];
			add_row($sformatf("random_%0d", i), r_cfg, r_usb, r_ext, r_key, r_ear, r_addr);
		end

		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// No read yet so no pulse and the idle byte
		for (int i = 0; i < 4; i++) begin
			checks++;
			if (rd_valid !== 1'b0 || rd_data !== 8'hFF) begin
				$display("rd_valid or rd_data wrong after reset without a read");
				errors++;
			end
			@(posedge clk_sys);
			#1;
		end

		for (int i = 0; i < num_rows; i++) begin
			apply_row(i);
			read_check(t_name[i], t_addr[i], t_exp[i]);
		end

		// ====================
		// Back-to-back reads
		// ====================

		apply_row(1);
		req.rd   = 1'b1;
		req.addr = 16'h001F;
		@(posedge clk_sys);
		#1;
		checks++;
		if (rd_valid !== 1'b1) begin
			$display("first back-to-back read got no valid pulse");
			errors++;
		end else if (rd_data !== t_exp[1]) begin
			$display("error back_to_back_1 expected %h actual %h", t_exp[1], rd_data);
			errors++;
		end
		req.addr = 16'h7FFD;
		@(posedge clk_sys);
		#1;
		req.rd = 1'b0;
		checks++;
		if (rd_valid !== 1'b1) begin
			$display("second back-to-back read got no valid pulse");
			errors++;
		end else if (rd_data !== 8'hFF) begin
			$display("error back_to_back_2 expected %h actual %h", 8'hFF, rd_data);
			errors++;
		end
		@(posedge clk_sys);
		#1;
		checks++;
		if (rd_valid !== 1'b0) begin
			$display("rd_valid stayed high after the last read");
			errors++;
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== joy_port_hub.sv ====
`timescale 1ns/10ps
`include "joy_defs.svh"

module joy_port_hub (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  joy_pkg::joy_cfg_t        cfg,
	input  joy_pkg::joy_state_t      usb_joy [0:`JOY_PLAYERS-1],
	input  logic [`EXT_RAW_BITS-1:0] ext_raw [0:`JOY_PLAYERS-1],
	input  joy_pkg::io_req_t         req,
	input  logic [`KEY_ROW_BITS-1:0] key_data,
	input  logic                     ear_in,
	output logic [`IO_DATA_BITS-1:0] rd_data,
	output logic                     rd_valid
);

	joy_pkg::joy_state_t player_joy  [0:`JOY_PLAYERS-1];
	joy_pkg::joy_keys_t  player_keys [0:`JOY_PLAYERS-1];

	// ====================
	// Source choice
	// ====================

	joy_source_select u_select (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.usb_joy    (usb_joy),
		.ext_raw    (ext_raw),
		.player_joy (player_joy)
	);

	// ====================
	// Per-player mapping
	// ====================

	// Player 0 takes Sinclair I in dual mode and the rest take Sinclair II
	for (genvar p = 0; p < `JOY_PLAYERS; p++) begin : g_map
		joy_player_map #(
			.sinclair1_in_dual (p == 0)
		) u_map (
			.clk_sys (clk_sys),
			.reset   (reset),
			.mode    (cfg.mode),
			.joy     (player_joy[p]),
			.keys    (player_keys[p])
		);
	end

	// ====================
	// CPU port reads
	// ====================

	joy_port_reader u_reader (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.keys     (player_keys),
		.req      (req),
		.key_data (key_data),
		.ear_in   (ear_in),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

endmodule

// ==== joy_port_reader.sv ====
`timescale 1ns/10ps
`include "joy_defs.svh"

module joy_port_reader (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  joy_pkg::joy_keys_t       keys [0:`JOY_PLAYERS-1],
	input  joy_pkg::io_req_t         req,
	input  logic [`KEY_ROW_BITS-1:0] key_data,
	input  logic                     ear_in,
	output logic [`IO_DATA_BITS-1:0] rd_data,
	output logic                     rd_valid
);

	// ====================
	// Player merge
	// ====================

	joy_pkg::joy_keys_t       merged;
	logic [`KEY_ROW_BITS-1:0] joy_kbd;
	logic [`IO_DATA_BITS-1:0] read_byte;

	always_comb begin
		merged = '0;
		for (int p = 0; p < `JOY_PLAYERS; p++) begin
			merged = merged | keys[p];
		end
	end

	// Half-row select lines are active low on the upper address byte
	// A12 picks keys 6..0 and A11 picks keys 1..5
	assign joy_kbd = ({`KEY_ROW_BITS{req.addr[12]}} | ~merged.row_67890) &
	                 ({`KEY_ROW_BITS{req.addr[11]}} | ~merged.row_12345);

	// ====================
	// Port decode
	// ====================

	always_comb begin
		if (req.addr[5:0] == `PORT_KEMPSTON) begin
			read_byte = {2'b00, merged.kempston};
		end else if (!req.addr[0]) begin
			// ULA port with EAR on bit 6
			read_byte = {1'b1, ear_in, 1'b1, key_data & joy_kbd};
		end else begin
			read_byte = 8'hFF;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_valid <= 1'b0;
			rd_data  <= 8'hFF;
		end else begin
			rd_valid <= req.rd;
			if (req.rd) begin
				rd_data <= read_byte;
			end
		end
	end

	// ====================
	// Checks
	// ====================

	// One pulse per strobe cycle
	a_valid_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		(rd_valid && $past(rd_valid)) |-> ($past(req.rd, 1) && $past(req.rd, 2))
	) else $error("rd_valid held without back-to-back reads");

endmodule

// ==== joy_player_map.sv ====
`timescale 1ns/10ps
`include "joy_defs.svh"

module joy_player_map #(
	// Row used by this player in dual Sinclair mode
	parameter bit sinclair1_in_dual = 1'b1
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [`JOY_MODE_BITS-1:0] mode,
	input  joy_pkg::joy_state_t       joy,
	output joy_pkg::joy_keys_t        keys
);

	// ====================
	// Row layouts
	// ====================

	logic [`KEY_ROW_BITS-1:0] sinclair1_row;
	logic [`KEY_ROW_BITS-1:0] sinclair2_row;
	logic [`KEY_ROW_BITS-1:0] cursor_row;
	logic                     cursor_left;
	joy_pkg::joy_keys_t       keys_next;

	// Keys 6 7 8 9 0 from bit 4 down
	assign sinclair1_row = {joy.left, joy.right, joy.down, joy.up, joy.fire1};

	// Keys 5 4 3 2 1 from bit 4 down
	assign sinclair2_row = {joy.fire1, joy.up, joy.down, joy.right, joy.left};

	// Cursor keys 6 7 8 plus fire on 0
	// Key 9 has no cursor meaning
	assign cursor_row  = {joy.down, joy.up, joy.right, 1'b0, joy.fire1};

	// Cursor left is key 5 on the other half-row
	assign cursor_left = joy.left;

	// ====================
	// Mode select
	// ====================

	always_comb begin
		keys_next = '0;
		case (mode)
			`MODE_KEMPSTON: begin
				keys_next.kempston = joy;
			end
			`MODE_SINCLAIR1: begin
				keys_next.row_67890 = sinclair1_row;
			end
			`MODE_SINCLAIR2: begin
				keys_next.row_12345 = sinclair2_row;
			end
			`MODE_SINCLAIR12: begin
				if (sinclair1_in_dual) begin
					keys_next.row_67890 = sinclair1_row;
				end else begin
					keys_next.row_12345 = sinclair2_row;
				end
			end
			`MODE_CURSOR: begin
				keys_next.row_67890 = cursor_row;
				keys_next.row_12345 = {cursor_left, {(`KEY_ROW_BITS-1){1'b0}}};
			end
			// Codes 5 to 7 map nothing
			default: begin
				keys_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			keys <= '0;
		end else begin
			keys <= keys_next;
		end
	end

	// ====================
	// Checks
	// ====================

	// Kempston bits only come out of Kempston mode
	a_kempston_only: assert property (
		@(posedge clk_sys) disable iff (reset)
		(mode != `MODE_KEMPSTON) |=> (keys.kempston == '0)
	) else $error("kempston bits set outside Kempston mode");

endmodule

// ==== joy_source_select.sv ====
`timescale 1ns/10ps
`include "joy_defs.svh"

module joy_source_select (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  joy_pkg::joy_cfg_t        cfg,
	input  joy_pkg::joy_state_t      usb_joy [0:`JOY_PLAYERS-1],
	input  logic [`EXT_RAW_BITS-1:0] ext_raw [0:`JOY_PLAYERS-1],
	output joy_pkg::joy_state_t      player_joy [0:`JOY_PLAYERS-1]
);

	// ====================
	// External decode
	// ====================

	// Two connector buttons share fire1
	function automatic joy_pkg::joy_state_t ext_decode(
		input logic [`EXT_RAW_BITS-1:0] raw
	);
		joy_pkg::joy_state_t st;
		st.right = raw[0];
		st.left  = raw[1];
		st.down  = raw[2];
		st.up    = raw[3];
		st.fire1 = raw[4] | raw[5];
		st.fire2 = raw[6];
		return st;
	endfunction

	joy_pkg::joy_state_t ext_joy [0:`JOY_PLAYERS-1];
	joy_pkg::joy_state_t sel_joy [0:`JOY_PLAYERS-1];

	// ====================
	// Source priority
	// ====================

	for (genvar p = 0; p < `JOY_PLAYERS; p++) begin : g_sel
		// Connector input is ignored while the OSD has focus
		assign ext_joy[p] = cfg.menu_open ? '0 : ext_decode(ext_raw[p]);

		if (p == 0) begin : g_first
			assign sel_joy[p] = cfg.ext_enable ? ext_joy[p] : usb_joy[p];
		end else begin : g_rest
			// One-player external mode pushes the USB pads up one slot
			assign sel_joy[p] = !cfg.ext_enable     ? usb_joy[p] :
			                    cfg.ext_two_players ? ext_joy[p] :
			                                          usb_joy[p-1];
		end
	end

	always_ff @(posedge clk_sys) begin
		for (int p = 0; p < `JOY_PLAYERS; p++) begin
			if (reset) begin
				player_joy[p] <= '0;
			end else begin
				player_joy[p] <= sel_joy[p];
			end
		end
	end

	// ====================
	// Checks
	// ====================

	for (genvar p = 0; p < `JOY_PLAYERS; p++) begin : g_chk
		a_reset_clear: assert property (
			@(posedge clk_sys) reset |=> (player_joy[p] == '0)
		) else $error("player %0d state not cleared by reset", p);
	end

endmodule

// ==== joy_pkg.sv ====
`include "joy_defs.svh"

package joy_pkg;

	// ====================
	// Joystick state
	// ====================

	// One player, active high, same order as the Kempston byte
	typedef struct packed {
		logic fire2;
		logic fire1;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_state_t;

	// One player's contribution to the ports
	// row_67890 bit 4 is key 6, bit 0 is key 0
	// row_12345 bit 0 is key 1, bit 4 is key 5
	typedef struct packed {
		logic [`JOY_BITS-1:0]     kempston;
		logic [`KEY_ROW_BITS-1:0] row_67890;
		logic [`KEY_ROW_BITS-1:0] row_12345;
	} joy_keys_t;

	// ====================
	// Control
	// ====================

	typedef struct packed {
		logic [`JOY_MODE_BITS-1:0] mode;
		logic                      ext_enable;
		logic                      ext_two_players;
		logic                      menu_open;
	} joy_cfg_t;

	// CPU port read strobe with full address
	typedef struct packed {
		logic                     rd;
		logic [`IO_ADDR_BITS-1:0] addr;
	} io_req_t;

endpackage

// ==== joy_defs.svh ====
`ifndef JOY_DEFS_SVH
`define JOY_DEFS_SVH

// ====================
// Sizes
// ====================

`define JOY_PLAYERS     2

// Joystick state is right left down up fire1 fire2 from bit 0
`define JOY_BITS        6

// External connector word as delivered by the DB9/DB15 decoders
`define EXT_RAW_BITS    7

`define KEY_ROW_BITS    5
`define IO_ADDR_BITS    16
`define IO_DATA_BITS    8

// ====================
// Ports and modes
// ====================

// Compared against addr[5:0] only
`define PORT_KEMPSTON   6'h1F

`define JOY_MODE_BITS   3
`define MODE_KEMPSTON   3'd0
`define MODE_SINCLAIR1  3'd1
`define MODE_SINCLAIR2  3'd2
`define MODE_SINCLAIR12 3'd3
`define MODE_CURSOR     3'd4

`endif
